// ==== include/voters.svh ====
`ifndef VOTERS_SVH
`define VOTERS_SVH

// Bitwise majority of three packed copies
`define VOTE3_MAJ(vote_in) \
    ((vote_in[0] & vote_in[1]) | (vote_in[0] & vote_in[2]) | (vote_in[1] & vote_in[2]))

// Whole-value majority of three enum copies
// Falls back to copy 1 when copy 0 is the odd one out
`define VOTE3_PICK(vote_in) \
    (((vote_in[0] == vote_in[1]) || (vote_in[0] == vote_in[2])) ? vote_in[0] : vote_in[1])

// Three copies in, one voted value out
`define VOTE3to1(vote_in, vote_out) \
    vote_out = `VOTE3_MAJ(vote_in)

// Three copies in, three voted copies out (vectors)
`define VOTE3to3(vote_in, vote_out) \
    vote_out[0] = `VOTE3_MAJ(vote_in); \
    vote_out[1] = `VOTE3_MAJ(vote_in); \
    vote_out[2] = `VOTE3_MAJ(vote_in)

// Three copies in, three voted copies out (enums)
`define VOTE3to3ENUM(vote_in, vote_out) \
    vote_out[0] = `VOTE3_PICK(vote_in); \
    vote_out[1] = `VOTE3_PICK(vote_in); \
    vote_out[2] = `VOTE3_PICK(vote_in)

`endif

// ==== design/dmr_cfg_pkg.sv ====
`default_nettype none

package dmr_cfg_pkg;

    // Copy ID width, four IDs are plenty for a strictly in-order pipeline
    localparam int unsigned IdSize = 2;
    localparam int unsigned NumIds = 1 << IdSize;

    // Voted state copies, the voter macros are written for exactly three
    localparam int unsigned NumReplicas = 3;

    // Issue phases of the start stage
    localparam logic [1:0] IssIdle  = 2'd0;
    localparam logic [1:0] IssLoad  = 2'd1;
    localparam logic [1:0] IssCopyA = 2'd2;
    localparam logic [1:0] IssCopyB = 2'd3;

    // Checker state, waiting for a first copy or holding one
    typedef enum logic {
        IDLE       = 1'b0,
        HAVE_FIRST = 1'b1
    } chk_state_e;

endpackage

`default_nettype wire

// ==== design/dmr_data_pkg.sv ====
`default_nettype none

package dmr_data_pkg;

    // Operand and result widths
    localparam int unsigned OpWidth  = 16;
    localparam int unsigned ResWidth = 32;

    // One operand set for a * b + c
    typedef struct packed {
        logic [OpWidth-1:0] a;
        logic [OpWidth-1:0] b;
        logic [OpWidth-1:0] c;
    } operands_t;

    // Result word, wraps modulo 2^32
    typedef logic [ResWidth-1:0] result_t;

endpackage

`default_nettype wire

// ==== design/time_dmr_start.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "voters.svh"

module time_dmr_start #(
    parameter type data_t = logic
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            enable_i,
    // Upstream
    input  data_t                           data_i,
    input  logic                            valid_i,
    output logic                            ready_o,
    // Downstream
    output data_t                           data_o,
    output logic [dmr_cfg_pkg::IdSize-1:0]  id_o,
    output logic                            valid_o,
    input  logic                            ready_i,
    // Direct link to the checker
    output logic [dmr_cfg_pkg::IdSize-1:0]  next_id_o
);

    //////////////////////////////////////////////////////////////////////
    // Triplicated issue phase and ID counter

    logic [dmr_cfg_pkg::NumReplicas-1:0][1:0]                     cnt_q, cnt_v, cnt_d;
    logic [dmr_cfg_pkg::NumReplicas-1:0][dmr_cfg_pkg::IdSize-1:0] id_q, id_v, id_d;
    logic [1:0]                                                   cnt_cur;
    logic [dmr_cfg_pkg::IdSize-1:0]                               id_cur;
    data_t                                                        data_q;

    for (genvar r = 0; r < dmr_cfg_pkg::NumReplicas; r++) begin : gen_issue
        always_comb begin
            cnt_v[r] = cnt_q[r];
            id_v[r]  = id_q[r];
            case (cnt_q[r])
                // Take a new set
                dmr_cfg_pkg::IssIdle: begin
                    if (valid_i) begin
                        cnt_v[r] = dmr_cfg_pkg::IssLoad;
                    end
                end
                // One cycle to fill the output register
                dmr_cfg_pkg::IssLoad: begin
                    cnt_v[r] = dmr_cfg_pkg::IssCopyA;
                end
                dmr_cfg_pkg::IssCopyA: begin
                    if (ready_i) begin
                        if (enable_i) begin
                            cnt_v[r] = dmr_cfg_pkg::IssCopyB;
                        end else begin
                            // Single pass, the set is done
                            cnt_v[r] = dmr_cfg_pkg::IssIdle;
                            id_v[r]  = id_q[r] + 1'b1;
                        end
                    end
                end
                default: begin
                    // Second copy leaves, move to the next ID
                    if (ready_i) begin
                        cnt_v[r] = dmr_cfg_pkg::IssIdle;
                        id_v[r]  = id_q[r] + 1'b1;
                    end
                end
            endcase
        end
    end

    always_comb begin : vote_comb
        `VOTE3to3(cnt_v, cnt_d);
        `VOTE3to3(id_v, id_d);
        `VOTE3to1(cnt_q, cnt_cur);
        `VOTE3to1(id_q, id_cur);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : state_ff
        if (!rst_ni) begin
            cnt_q <= '0;
            id_q  <= '0;
        end else begin
            cnt_q <= cnt_d;
            id_q  <= id_d;
        end
    end

    // Operand set held for both copies
    always_ff @(posedge clk_i) begin : data_ff
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Outputs

    assign ready_o   = (cnt_cur == dmr_cfg_pkg::IssIdle);
    assign valid_o   = (cnt_cur == dmr_cfg_pkg::IssCopyA) || (cnt_cur == dmr_cfg_pkg::IssCopyB);
    assign data_o    = data_q;
    assign id_o      = id_cur;
    // Checker frees this ID ahead of its use
    assign next_id_o = id_cur + 1'b1;

    // Both copies must carry identical operands
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

`default_nettype wire

// ==== design/mul_add_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_add_pipe (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    // Upstream
    input  dmr_data_pkg::operands_t         ops_i,
    input  logic [dmr_cfg_pkg::IdSize-1:0]  id_i,
    input  logic                            valid_i,
    output logic                            ready_o,
    // Upset stand-in, flips result bit 0
    input  logic                            fault_i,
    // Downstream
    output dmr_data_pkg::result_t           res_o,
    output logic [dmr_cfg_pkg::IdSize-1:0]  id_o,
    output logic                            valid_o,
    input  logic                            ready_i
);

    logic                              s1_valid_q, s2_valid_q;
    dmr_data_pkg::result_t             s1_prod_q, s2_sum_q;
    logic [dmr_data_pkg::OpWidth-1:0]  s1_c_q;
    logic [dmr_cfg_pkg::IdSize-1:0]    s1_id_q, s2_id_q;
    logic                              stall;

    // Whole pipe freezes while the output waits
    assign stall   = s2_valid_q && !ready_i;
    assign ready_o = !stall;

    always_ff @(posedge clk_i or negedge rst_ni) begin : valid_ff
        if (!rst_ni) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (!stall) begin
            s1_valid_q <= valid_i;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin : payload_ff
        // Stage 1 multiply
        if (!stall && valid_i) begin
            s1_prod_q <= dmr_data_pkg::result_t'(ops_i.a) * dmr_data_pkg::result_t'(ops_i.b);
            s1_c_q    <= ops_i.c;
            s1_id_q   <= id_i;
        end
        // Stage 2 add
        if (!stall && s1_valid_q) begin
            s2_sum_q <= s1_prod_q + dmr_data_pkg::result_t'(s1_c_q);
            s2_id_q  <= s1_id_q;
        end
    end

    assign res_o   = s2_sum_q ^ dmr_data_pkg::result_t'(fault_i);
    assign id_o    = s2_id_q;
    assign valid_o = s2_valid_q;

    // A held result stays in place
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o && !ready_i |=> valid_o && $stable(id_o));

endmodule

`default_nettype wire

// ==== design/time_dmr_end.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "voters.svh"

module time_dmr_end #(
    parameter type data_t = logic
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            enable_i,
    // Direct link from the start stage
    input  logic [dmr_cfg_pkg::IdSize-1:0]  next_id_i,
    // Upstream
    input  data_t                           data_i,
    input  logic [dmr_cfg_pkg::IdSize-1:0]  id_i,
    input  logic                            valid_i,
    output logic                            ready_o,
    // Downstream
    output data_t                           data_o,
    output logic [dmr_cfg_pkg::IdSize-1:0]  id_o,
    output logic                            faulty_o,
    output logic                            valid_o,
    input  logic                            ready_i
);

    localparam int unsigned DataBits = $bits(data_t);

    //////////////////////////////////////////////////////////////////////
    // Triplicated checker state

    dmr_cfg_pkg::chk_state_e state_q [dmr_cfg_pkg::NumReplicas];
    dmr_cfg_pkg::chk_state_e state_v [dmr_cfg_pkg::NumReplicas];
    dmr_cfg_pkg::chk_state_e state_d [dmr_cfg_pkg::NumReplicas];

    // Stored first copy and its ID
    logic [dmr_cfg_pkg::NumReplicas-1:0][DataBits-1:0]            first_q, first_v, first_d;
    logic [dmr_cfg_pkg::NumReplicas-1:0][dmr_cfg_pkg::IdSize-1:0] id_q, id_v, id_d;
    // IDs already sent downstream
    logic [dmr_cfg_pkg::NumReplicas-1:0][dmr_cfg_pkg::NumIds-1:0] seen_q, seen_v, seen_d;

    // Per-copy handshake opinions, voted below
    logic [dmr_cfg_pkg::NumReplicas-1:0] valid_ov, ready_ov, faulty_ov;

    for (genvar r = 0; r < dmr_cfg_pkg::NumReplicas; r++) begin : gen_check
        always_comb begin
            logic match;

            first_v[r] = first_q[r];
            id_v[r]    = id_q[r];
            state_v[r] = state_q[r];
            seen_v[r]  = seen_q[r];

            // Start is about to reuse this ID
            seen_v[r][next_id_i] = 1'b0;

            // Second copy of the held set, not yet sent
            match = valid_i && (state_q[r] == dmr_cfg_pkg::HAVE_FIRST)
                    && (id_i == id_q[r]) && !seen_q[r][id_i];

            if (!enable_i) begin
                // Redundancy off, pass straight through
                valid_ov[r]  = valid_i;
                ready_ov[r]  = ready_i;
                faulty_ov[r] = 1'b0;
                state_v[r]   = dmr_cfg_pkg::IDLE;
            end else if (match) begin
                valid_ov[r]  = 1'b1;
                ready_ov[r]  = ready_i;
                faulty_ov[r] = (data_i != first_q[r]);
                if (ready_i) begin
                    state_v[r]        = dmr_cfg_pkg::IDLE;
                    seen_v[r][id_i]   = 1'b1;
                end
            end else begin
                // First copy or a stale duplicate, always taken
                valid_ov[r]  = 1'b0;
                ready_ov[r]  = 1'b1;
                faulty_ov[r] = 1'b0;
                if (valid_i && !seen_q[r][id_i]) begin
                    first_v[r] = data_i;
                    id_v[r]    = id_i;
                    state_v[r] = dmr_cfg_pkg::HAVE_FIRST;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Voting

    always_comb begin : vote_state_comb
        `VOTE3to3ENUM(state_v, state_d);
        `VOTE3to3(first_v, first_d);
        `VOTE3to3(id_v, id_d);
        `VOTE3to3(seen_v, seen_d);
    end

    always_comb begin : vote_out_comb
        `VOTE3to1(valid_ov, valid_o);
        `VOTE3to1(ready_ov, ready_o);
        `VOTE3to1(faulty_ov, faulty_o);
    end

    //////////////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_ff
        if (!rst_ni) begin
            state_q <= '{default: dmr_cfg_pkg::IDLE};
            id_q    <= '0;
            seen_q  <= '0;
        end else begin
            state_q <= state_d;
            id_q    <= id_d;
            seen_q  <= seen_d;
        end
    end

    always_ff @(posedge clk_i) begin : first_ff
        first_q <= first_d;
    end

    // Presented result is the second copy
    assign data_o = data_i;
    assign id_o   = id_i;

    // Fault flag only ever rides on an output transfer
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        faulty_o |-> valid_o);

endmodule

`default_nettype wire

// ==== design/dmr_mul_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmr_mul_top (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              enable_i,
    input  logic                              fault_i,
    // Operand input
    input  logic [dmr_data_pkg::OpWidth-1:0]  op_a_i,
    input  logic [dmr_data_pkg::OpWidth-1:0]  op_b_i,
    input  logic [dmr_data_pkg::OpWidth-1:0]  op_c_i,
    input  logic                              in_valid_i,
    output logic                              in_ready_o,
    // Result output
    output dmr_data_pkg::result_t             res_o,
    output logic                              faulty_o,
    output logic                              out_valid_o,
    input  logic                              out_ready_i
);

    dmr_data_pkg::operands_t         ops_in, ops_iss;
    logic [dmr_cfg_pkg::IdSize-1:0]  iss_id, pipe_id, next_id;
    logic                            iss_valid, iss_ready;
    dmr_data_pkg::result_t           pipe_res;
    logic                            pipe_valid, pipe_ready;

    assign ops_in.a = op_a_i;
    assign ops_in.b = op_b_i;
    assign ops_in.c = op_c_i;

    //////////////////////////////////////////////////////////////////////
    // Issue, compute, check

    time_dmr_start #(
        .data_t (dmr_data_pkg::operands_t)
    ) start_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .enable_i  (enable_i),
        .data_i    (ops_in),
        .valid_i   (in_valid_i),
        .ready_o   (in_ready_o),
        .data_o    (ops_iss),
        .id_o      (iss_id),
        .valid_o   (iss_valid),
        .ready_i   (iss_ready),
        .next_id_o (next_id)
    );

    mul_add_pipe pipe_i (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .ops_i   (ops_iss),
        .id_i    (iss_id),
        .valid_i (iss_valid),
        .ready_o (iss_ready),
        .fault_i (fault_i),
        .res_o   (pipe_res),
        .id_o    (pipe_id),
        .valid_o (pipe_valid),
        .ready_i (pipe_ready)
    );

    time_dmr_end #(
        .data_t (dmr_data_pkg::result_t)
    ) end_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .enable_i  (enable_i),
        .next_id_i (next_id),
        .data_i    (pipe_res),
        .id_i      (pipe_id),
        .valid_i   (pipe_valid),
        .ready_o   (pipe_ready),
        .data_o    (res_o),
        .id_o      (),
        .faulty_o  (faulty_o),
        .valid_o   (out_valid_o),
        .ready_i   (out_ready_i)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int unsigned PeriodNs    = 8,
    parameter int unsigned ResetCycles = 4
) (
    output logic clk_o,
    output logic rst_no
);

    // Free-running clock
    initial begin : clock_seq
        clk_o = 1'b0;
        forever #(PeriodNs / 2) clk_o = ~clk_o;
    end

    // Reset held for a few edges, released away from the rising edge
    initial begin : reset_seq
        rst_no = 1'b0;
        repeat (ResetCycles) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/dmr_mul_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmr_mul_tb;

    // Random sets plus the three single-set cases
    localparam int unsigned NumSets   = 200 + 50 + 3;
    localparam int unsigned MaxCycles = 20 * NumSets + 200;

    logic                             clk_i, rst_ni;
    logic                             enable_i, fault_i;
    logic [dmr_data_pkg::OpWidth-1:0] op_a_i, op_b_i, op_c_i;
    logic                             in_valid_i, in_ready_o;
    dmr_data_pkg::result_t            res_o;
    logic                             faulty_o, out_valid_o, out_ready_i;

    // Expected results with one entry per accepted set
    dmr_data_pkg::result_t exp_res_q [$];
    logic                  exp_flt_q [$];

    logic [15:0] lfsr_q;
    int unsigned out_count    = 0;
    int unsigned checks       = 0;
    int unsigned mismatch_cnt = 0;
    int unsigned other_cnt    = 0;
    int unsigned cycle_cnt    = 0;

    tb_clock_gen #(
        .PeriodNs    (8),
        .ResetCycles (4)
    ) clock_gen_i (
        .clk_o  (clk_i),
        .rst_no (rst_ni)
    );

    dmr_mul_top dmr_mul_top_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .enable_i    (enable_i),
        .fault_i     (fault_i),
        .op_a_i      (op_a_i),
        .op_b_i      (op_b_i),
        .op_c_i      (op_c_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .res_o       (res_o),
        .faulty_o    (faulty_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

    //////////////////////////////////////////////////////////////////////
    // Random source and reference model

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] nxt;
        nxt = state >> 1;
        if (state[0]) begin
            nxt = nxt ^ 16'hB400;
        end
        return nxt;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] value;
        value = '0;
        for (int unsigned i = 0; i < n; i++) begin
            value  = {value[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return value;
    endfunction

    // a * b + c wrapping at 32 bits
    function automatic dmr_data_pkg::result_t mul_add_model(input logic [15:0] a, b, c);
        logic [31:0] prod;
        prod = {16'b0, a} * {16'b0, b};
        return prod + {16'b0, c};
    endfunction

    task automatic push_expected(input logic flip, input logic flt);
        exp_res_q.push_back(mul_add_model(op_a_i, op_b_i, op_c_i) ^ {31'b0, flip});
        exp_flt_q.push_back(flt);
    endtask

    task automatic drive_random_ops();
        logic [31:0] rnd;
        rnd = rand_bits(16);
        op_a_i <= rnd[15:0];
        rnd = rand_bits(16);
        op_b_i <= rnd[15:0];
        rnd = rand_bits(16);
        op_c_i <= rnd[15:0];
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus tasks

    // Random sets and random gaps while the output side is ready about 3 cycles in 4
    task automatic run_traffic(input int unsigned num_sets);
        int unsigned issued;
        logic        pending;
        logic [31:0] rnd;
        issued  = 0;
        pending = 1'b0;
        while (issued < num_sets || pending) begin
            @(posedge clk_i);
            rnd = rand_bits(2);
            out_ready_i <= (rnd[1:0] != 2'b00);
            if (pending && in_ready_o) begin
                // Set transfers on this edge
                push_expected(1'b0, 1'b0);
                in_valid_i <= 1'b0;
                pending = 1'b0;
            end else if (!pending && issued < num_sets) begin
                rnd = rand_bits(1);
                if (rnd[0]) begin
                    drive_random_ops();
                    in_valid_i <= 1'b1;
                    pending = 1'b1;
                    issued++;
                end
            end
        end
        out_ready_i <= 1'b1;
    endtask

    // Returns on the accepting edge N
    task automatic send_single(input logic flip, input logic flt);
        @(posedge clk_i);
        drive_random_ops();
        in_valid_i <= 1'b1;
        @(posedge clk_i);
        while (!in_ready_o) @(posedge clk_i);
        push_expected(flip, flt);
        in_valid_i <= 1'b0;
    endtask

    // Waits for every expected result and a few quiet cycles
    task automatic wait_for_drain();
        while (exp_res_q.size() != 0) @(posedge clk_i);
        repeat (4) @(posedge clk_i);
    endtask

    task automatic check_latency();
        send_single(1'b0, 1'b0);
        for (int k = 1; k <= 4; k++) begin
            @(posedge clk_i);
            checks++;
            if (out_valid_o) begin
                $display("MISMATCH at %0t: out_valid_o before edge N+%0d expected 0 got 1",
                         $time, k);
                mismatch_cnt++;
            end
        end
        @(posedge clk_i);
        checks++;
        if (!out_valid_o) begin
            $display("MISMATCH at %0t: out_valid_o after edge N+4 expected 1 got 0", $time);
            mismatch_cnt++;
        end
    endtask

    // Upset pulse one cycle wide starting at edge N+delay
    task automatic check_fault(input int unsigned delay, input logic flip);
        send_single(flip, 1'b1);
        repeat (delay) @(posedge clk_i);
        fault_i <= 1'b1;
        @(posedge clk_i);
        fault_i <= 1'b0;
    endtask

    task automatic check_count(input int unsigned got, input int unsigned want);
        checks++;
        if (got != want) begin
            $display("MISMATCH at %0t: output count expected %0d got %0d", $time, want, got);
            mismatch_cnt++;
        end
    endtask

    task automatic print_summary();
        $display("Checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatch_cnt, other_cnt);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output monitor and watchdog

    always @(posedge clk_i) begin : output_monitor
        dmr_data_pkg::result_t exp_res;
        logic                  exp_flt;
        if (rst_ni && out_valid_o && out_ready_i) begin
            out_count++;
            if (exp_res_q.size() == 0) begin
                $display("%0t: result came out with no set pending", $time);
                other_cnt++;
            end else begin
                exp_res = exp_res_q.pop_front();
                exp_flt = exp_flt_q.pop_front();
                checks += 2;
                if (res_o !== exp_res) begin
                    $display("MISMATCH at %0t: res_o expected %h got %h", $time, exp_res, res_o);
                    mismatch_cnt++;
                end
                if (faulty_o !== exp_flt) begin
                    $display("MISMATCH at %0t: faulty_o expected %b got %b",
                             $time, exp_flt, faulty_o);
                    mismatch_cnt++;
                end
            end
        end
    end

    always @(posedge clk_i) begin : watchdog
        cycle_cnt++;
        if (cycle_cnt >= MaxCycles) begin
            $display("Timeout, run still busy after %0d cycles", MaxCycles);
            print_summary();
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin : main_seq
        int unsigned base;
        enable_i    = 1'b1;
        fault_i     = 1'b0;
        op_a_i      = '0;
        op_b_i      = '0;
        op_c_i      = '0;
        in_valid_i  = 1'b0;
        out_ready_i = 1'b1;
        lfsr_q      = 16'd23006;

        @(posedge rst_ni);
        @(posedge clk_i);
        checks += 3;
        if (out_valid_o !== 1'b0) begin
            $display("MISMATCH at %0t: out_valid_o after reset expected 0 got %b",
                     $time, out_valid_o);
            mismatch_cnt++;
        end
        if (faulty_o !== 1'b0) begin
            $display("MISMATCH at %0t: faulty_o after reset expected 0 got %b",
                     $time, faulty_o);
            mismatch_cnt++;
        end
        if (in_ready_o !== 1'b1) begin
            $display("MISMATCH at %0t: in_ready_o after reset expected 1 got %b",
                     $time, in_ready_o);
            mismatch_cnt++;
        end

        // Redundant traffic under back-pressure
        base = out_count;
        run_traffic(200);
        wait_for_drain();
        check_count(out_count - base, 200);

        check_latency();
        wait_for_drain();

        // Upset on copy A and then on copy B
        check_fault(3, 1'b0);
        wait_for_drain();
        check_fault(4, 1'b1);
        wait_for_drain();

        // Single pass without checking
        enable_i <= 1'b0;
        @(posedge clk_i);
        base = out_count;
        run_traffic(50);
        wait_for_drain();
        check_count(out_count - base, 50);

        print_summary();
        if (mismatch_cnt + other_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
design/dmr_cfg_pkg.sv
design/dmr_data_pkg.sv
design/time_dmr_start.sv
design/mul_add_pipe.sv
design/time_dmr_end.sv
design/dmr_mul_top.sv
verif/tb_clock_gen.sv
verif/dmr_mul_tb.sv

// ==== Makefile ====
# Verilator build and run for the time-redundant multiply-add

VERILATOR ?= verilator
TOP       ?= dmr_mul_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
